/* common/bridge_pkg.sv */
//////////////////////////////////////////////////////////////////////
// widths, counts and types shared across the uart to spi bridge
// CLKS_PER_BIT suits simulation, use 868 for 115200 baud at 100 MHz
// SPI_HALF_SCK must be 2 or more
//////////////////////////////////////////////////////////////////////
package bridge_pkg;

  // data widths
  localparam int BYTE_W     = 8;
  localparam int SPI_WORD_W = 16;

  // uart bit timing
  localparam int CLKS_PER_BIT  = 16;
  localparam int UART_CNT_W    = $clog2(CLKS_PER_BIT);
  // start bit is index 0, stop bit sits after the data bits
  localparam int UART_STOP_IDX = BYTE_W + 1;
  localparam int UART_IDX_W    = $clog2(UART_STOP_IDX + 1);

  // spi clock divider and bit counter
  localparam int SPI_HALF_SCK = 2;
  localparam int SPI_DIV_W    = $clog2(SPI_HALF_SCK);
  localparam int SPI_BIT_W    = $clog2(SPI_WORD_W);

  // slm reset stretch
  localparam int RESET_HOLD  = 10;
  localparam int RESET_CNT_W = $clog2(RESET_HOLD + 1);

  // readback fifo
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = 2;

  // start pulse plus address/data word for the spi master
  typedef struct packed {
    logic                  start;
    logic [SPI_WORD_W-1:0] word;
  } spi_req_t;

  // start pulse plus reply byte for the uart transmitter
  typedef struct packed {
    logic              start;
    logic [BYTE_W-1:0] tx_byte;
  } uart_tx_req_t;

  // readback drain states
  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_FETCH,
    SEQ_LAUNCH
  } seq_state_e;

endpackage

/* design/reset_stretch.sv */
//////////////////////////////////////////////////////////////////////
// holds reset for RESET_HOLD cycles after the command falls
// counter is undefined until the command has been high once
//////////////////////////////////////////////////////////////////////
module reset_stretch
  import bridge_pkg::*;
(
  input  logic sys_clk,
  input  logic reset_all_cmd_w,
  output logic reset_hold_o
);

  // cycles left in the stretch
  logic [RESET_CNT_W-1:0] hold_cnt;

  // reload while the command is up, then run down to zero
  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      hold_cnt <= RESET_CNT_W'(RESET_HOLD);
    end else if (hold_cnt != '0) begin
      hold_cnt <= hold_cnt - 1'b1;
    end
  end

  // command passes straight through, counter covers the tail
  assign reset_hold_o = reset_all_cmd_w | (hold_cnt != '0);

endmodule

/* uart/uart_rx.sv */
//////////////////////////////////////////////////////////////////////
// 8N1 receiver, LSB first, no parity
// a frame with a low stop bit is dropped without notice
//////////////////////////////////////////////////////////////////////
module uart_rx
  import bridge_pkg::*;
(
  input  logic              sys_clk,
  input  logic              rst_i,
  input  logic              rx_serial_i,
  output logic              rx_valid_o,
  output logic [BYTE_W-1:0] rx_byte_o
);

  logic [1:0]            rx_sync;
  logic                  rx_bit;
  logic                  rx_busy;
  logic [UART_CNT_W-1:0] clk_cnt;
  logic [UART_CNT_W-1:0] wait_len;
  logic [UART_IDX_W-1:0] bit_idx;
  logic                  sample_now;
  logic [BYTE_W-1:0]     shift_q;
  logic                  valid_q;

  // two flops against metastability, line idles high
  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      rx_sync <= 2'b11;
    end else begin
      rx_sync <= {rx_sync[0], rx_serial_i};
    end
  end

  assign rx_bit = rx_sync[1];

  // half a bit to reach mid start, then whole bits
  assign wait_len   = (bit_idx == '0) ? UART_CNT_W'(CLKS_PER_BIT / 2 - 1)
                                      : UART_CNT_W'(CLKS_PER_BIT - 1);
  assign sample_now = rx_busy && (clk_cnt == wait_len);

  //////////////////////////////////////////////////////////////////////
  // frame control
  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      rx_busy <= 1'b0;
      clk_cnt <= '0;
      bit_idx <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      if (!rx_busy) begin
        clk_cnt <= '0;
        bit_idx <= '0;
        // falling edge on the line
        if (!rx_bit) begin
          rx_busy <= 1'b1;
        end
      end else if (!sample_now) begin
        clk_cnt <= clk_cnt + 1'b1;
      end else begin
        clk_cnt <= '0;
        bit_idx <= bit_idx + 1'b1;
        if ((bit_idx == '0) && rx_bit) begin
          // glitch, start bit gone by mid-bit
          rx_busy <= 1'b0;
        end else if (bit_idx == UART_IDX_W'(UART_STOP_IDX)) begin
          // mid stop bit
          rx_busy <= 1'b0;
          valid_q <= rx_bit;
        end
      end
    end
  end

  // data bits land LSB first
  always_ff @(posedge sys_clk) begin
    if (sample_now && (bit_idx != '0) && (bit_idx != UART_IDX_W'(UART_STOP_IDX))) begin
      shift_q <= {rx_bit, shift_q[BYTE_W-1:1]};
    end
  end

  assign rx_valid_o = valid_q;
  assign rx_byte_o  = shift_q;

endmodule

/* uart/uart_tx.sv */
//////////////////////////////////////////////////////////////////////
// 8N1 transmitter, LSB first
// a start strobe while active is ignored
//////////////////////////////////////////////////////////////////////
module uart_tx
  import bridge_pkg::*;
(
  input  logic         sys_clk,
  input  logic         rst_i,
  input  uart_tx_req_t tx_req_i,
  output logic         tx_active_o,
  output logic         tx_serial_o
);

  logic                  tx_busy;
  logic [UART_CNT_W-1:0] clk_cnt;
  logic [UART_IDX_W-1:0] bit_idx;
  logic                  bit_end;
  // stop, data, start with the start bit at the bottom
  logic [BYTE_W+1:0]     frame_q;

  assign bit_end = tx_busy && (clk_cnt == UART_CNT_W'(CLKS_PER_BIT - 1));

  // bit timing and frame length
  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      tx_busy <= 1'b0;
      clk_cnt <= '0;
      bit_idx <= '0;
    end else if (!tx_busy) begin
      clk_cnt <= '0;
      bit_idx <= '0;
      if (tx_req_i.start) begin
        tx_busy <= 1'b1;
      end
    end else if (!bit_end) begin
      clk_cnt <= clk_cnt + 1'b1;
    end else begin
      clk_cnt <= '0;
      bit_idx <= bit_idx + 1'b1;
      // stop bit done
      if (bit_idx == UART_IDX_W'(UART_STOP_IDX)) begin
        tx_busy <= 1'b0;
      end
    end
  end

  // latch on start, shift out one bit per bit time
  always_ff @(posedge sys_clk) begin
    if (!tx_busy && tx_req_i.start) begin
      frame_q <= {1'b1, tx_req_i.tx_byte, 1'b0};
    end else if (bit_end) begin
      frame_q <= {1'b1, frame_q[BYTE_W+1:1]};
    end
  end

  // line idles high
  assign tx_serial_o = tx_busy ? frame_q[0] : 1'b1;
  assign tx_active_o = tx_busy;

endmodule

/* spi/spi_master.sv */
//////////////////////////////////////////////////////////////////////
// mode 0 master, one 16-bit word per start, MSB first
// SDAT moves with SCK falling, MISO sampled as SCK rises
//////////////////////////////////////////////////////////////////////
module spi_master
  import bridge_pkg::*;
(
  input  logic              sys_clk,
  input  logic              rst_i,
  input  spi_req_t          req_i,
  output logic              busy_o,
  output logic [BYTE_W-1:0] rx_byte_o,
  output logic              sen_o,
  output logic              sck_o,
  output logic              sdat_o,
  input  logic              sout_i
);

  logic                  busy_q;
  logic                  sck_q;
  logic [SPI_DIV_W-1:0]  div_cnt;
  logic [SPI_BIT_W-1:0]  bit_cnt;
  logic                  half_end;
  logic [SPI_WORD_W-1:0] tx_shift;
  // only the last byte shifted in is kept
  logic [BYTE_W-1:0]     rx_shift;

  assign half_end = busy_q && (div_cnt == SPI_DIV_W'(SPI_HALF_SCK - 1));

  //////////////////////////////////////////////////////////////////////
  // sck divider and bit count
  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      busy_q  <= 1'b0;
      sck_q   <= 1'b0;
      div_cnt <= '0;
      bit_cnt <= '0;
    end else if (!busy_q) begin
      sck_q   <= 1'b0;
      div_cnt <= '0;
      bit_cnt <= '0;
      if (req_i.start) begin
        busy_q <= 1'b1;
      end
    end else if (!half_end) begin
      div_cnt <= div_cnt + 1'b1;
    end else begin
      div_cnt <= '0;
      sck_q   <= ~sck_q;
      // falling edge closes a bit
      if (sck_q) begin
        if (bit_cnt == SPI_BIT_W'(SPI_WORD_W - 1)) begin
          busy_q <= 1'b0;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // data shifters
  always_ff @(posedge sys_clk) begin
    if (!busy_q && req_i.start) begin
      tx_shift <= req_i.word;
    end else if (half_end && sck_q) begin
      // next bit out on the falling edge
      tx_shift <= {tx_shift[SPI_WORD_W-2:0], 1'b0};
    end
  end

  // capture MISO as sck goes high
  always_ff @(posedge sys_clk) begin
    if (half_end && !sck_q) begin
      rx_shift <= {rx_shift[BYTE_W-2:0], sout_i};
    end
  end

  assign busy_o    = busy_q;
  assign sen_o     = ~busy_q;
  assign sck_o     = sck_q;
  // MOSI parked low between words
  assign sdat_o    = busy_q & tx_shift[SPI_WORD_W-1];
  // held until the next transfer
  assign rx_byte_o = rx_shift;

endmodule

/* design/readback_fifo.sv */
//////////////////////////////////////////////////////////////////////
// FIFO_DEPTH-entry byte FIFO, head shown without a read
// a write to a full FIFO is lost, a read when empty is ignored
//////////////////////////////////////////////////////////////////////
module readback_fifo
  import bridge_pkg::*;
(
  input  logic              sys_clk,
  input  logic              rst_i,
  input  logic              wr_en_i,
  input  logic [BYTE_W-1:0] wr_byte_i,
  output logic              full_o,
  input  logic              rd_en_i,
  output logic [BYTE_W-1:0] rd_byte_o,
  output logic              empty_o
);

  logic [BYTE_W-1:0]   mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  // one extra bit so a full FIFO is countable
  logic [FIFO_PTR_W:0] count;
  logic                do_wr;
  logic                do_rd;

  assign full_o  = (count == (FIFO_PTR_W + 1)'(FIFO_DEPTH));
  assign empty_o = (count == '0);
  assign do_wr   = wr_en_i && !full_o;
  assign do_rd   = rd_en_i && !empty_o;

  // pointers wrap naturally
  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // simultaneous read and write leaves the count alone
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_byte_i;
    end
  end

  assign rd_byte_o = mem[rd_ptr];

endmodule

/* design/cmd_sequencer.sv */
//////////////////////////////////////////////////////////////////////
// pairs host bytes into spi words, address first, and echoes
// each spi readback to the uart; first byte after reset is an address
//////////////////////////////////////////////////////////////////////
module cmd_sequencer
  import bridge_pkg::*;
(
  input  logic              sys_clk,
  input  logic              rst_i,
  input  logic              rx_valid_i,
  input  logic [BYTE_W-1:0] rx_byte_i,
  output spi_req_t          spi_req_o,
  input  logic              spi_busy_i,
  output logic              fifo_wr_o,
  input  logic              fifo_full_i,
  output logic              fifo_rd_o,
  input  logic              fifo_empty_i,
  input  logic [BYTE_W-1:0] fifo_byte_i,
  output uart_tx_req_t      tx_req_o,
  input  logic              tx_active_i
);

  seq_state_e            state_q;
  seq_state_e            state_d;
  logic [SPI_WORD_W-1:0] pair_q;
  logic                  have_addr_q;
  logic                  spi_start_q;
  logic                  busy_q;
  logic [BYTE_W-1:0]     reply_q;

  //////////////////////////////////////////////////////////////////////
  // byte pairing
  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      have_addr_q <= 1'b0;
      spi_start_q <= 1'b0;
      busy_q      <= 1'b0;
    end else begin
      // second byte of a pair fires the transfer
      spi_start_q <= rx_valid_i && have_addr_q;
      if (rx_valid_i) begin
        have_addr_q <= ~have_addr_q;
      end
      busy_q <= spi_busy_i;
    end
  end

  // older byte moves up into the address half
  always_ff @(posedge sys_clk) begin
    if (rx_valid_i) begin
      pair_q <= {pair_q[BYTE_W-1:0], rx_byte_i};
    end
  end

  assign spi_req_o.start = spi_start_q;
  assign spi_req_o.word  = pair_q;

  // busy falling edge, readback dropped when the FIFO is full
  assign fifo_wr_o = busy_q && !spi_busy_i && !fifo_full_i;

  //////////////////////////////////////////////////////////////////////
  // readback drain
  always_comb begin
    state_d = state_q;
    case (state_q)
      SEQ_IDLE: begin
        if (!fifo_empty_i && !tx_active_i) begin
          state_d = SEQ_FETCH;
        end
      end
      SEQ_FETCH:  state_d = SEQ_LAUNCH;
      // tx is active by the next cycle
      SEQ_LAUNCH: state_d = SEQ_IDLE;
      default:    state_d = SEQ_IDLE;
    endcase
  end

  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      state_q <= SEQ_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // grab the head as it is popped
  always_ff @(posedge sys_clk) begin
    if (state_q == SEQ_FETCH) begin
      reply_q <= fifo_byte_i;
    end
  end

  assign fifo_rd_o        = (state_q == SEQ_FETCH);
  assign tx_req_o.start   = (state_q == SEQ_LAUNCH);
  assign tx_req_o.tx_byte = reply_q;

endmodule

/* design/bridge_top.sv */
//////////////////////////////////////////////////////////////////////
// uart to spi bridge for the slm driver board
// every block runs from the stretched reset
//////////////////////////////////////////////////////////////////////
module bridge_top
  import bridge_pkg::*;
(
  input  logic sys_clk,
  input  logic reset_all_cmd_w,
  // host uart
  input  logic uart_rx_i,
  output logic uart_tx_o,
  // slm spi, sen active low
  output logic spi_sen_o,
  output logic spi_sck_o,
  output logic spi_sdat_o,
  input  logic spi_sout_i,
  // slm reset, active low
  output logic slm_reset_n_o
);

  logic              rst_hold;
  logic              rx_valid;
  logic [BYTE_W-1:0] rx_byte;
  spi_req_t          spi_req;
  logic              spi_busy;
  logic [BYTE_W-1:0] spi_rx_byte;
  logic              fifo_wr;
  logic              fifo_full;
  logic              fifo_rd;
  logic              fifo_empty;
  logic [BYTE_W-1:0] fifo_byte;
  uart_tx_req_t      tx_req;
  logic              tx_active;

  reset_stretch u_reset (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .reset_hold_o    (rst_hold)
  );

  assign slm_reset_n_o = ~rst_hold;

  uart_rx u_uart_rx (
    .sys_clk     (sys_clk),
    .rst_i       (rst_hold),
    .rx_serial_i (uart_rx_i),
    .rx_valid_o  (rx_valid),
    .rx_byte_o   (rx_byte)
  );

  uart_tx u_uart_tx (
    .sys_clk     (sys_clk),
    .rst_i       (rst_hold),
    .tx_req_i    (tx_req),
    .tx_active_o (tx_active),
    .tx_serial_o (uart_tx_o)
  );

  spi_master u_spi (
    .sys_clk   (sys_clk),
    .rst_i     (rst_hold),
    .req_i     (spi_req),
    .busy_o    (spi_busy),
    .rx_byte_o (spi_rx_byte),
    .sen_o     (spi_sen_o),
    .sck_o     (spi_sck_o),
    .sdat_o    (spi_sdat_o),
    .sout_i    (spi_sout_i)
  );

  readback_fifo u_fifo (
    .sys_clk   (sys_clk),
    .rst_i     (rst_hold),
    .wr_en_i   (fifo_wr),
    .wr_byte_i (spi_rx_byte),
    .full_o    (fifo_full),
    .rd_en_i   (fifo_rd),
    .rd_byte_o (fifo_byte),
    .empty_o   (fifo_empty)
  );

  cmd_sequencer u_seq (
    .sys_clk      (sys_clk),
    .rst_i        (rst_hold),
    .rx_valid_i   (rx_valid),
    .rx_byte_i    (rx_byte),
    .spi_req_o    (spi_req),
    .spi_busy_i   (spi_busy),
    .fifo_wr_o    (fifo_wr),
    .fifo_full_i  (fifo_full),
    .fifo_rd_o    (fifo_rd),
    .fifo_empty_i (fifo_empty),
    .fifo_byte_i  (fifo_byte),
    .tx_req_o     (tx_req),
    .tx_active_i  (tx_active)
  );

endmodule

/* dv/bridge_asserts.sv */
//////////////////////////////////////////////////////////////////////
// protocol checks on the sequencer ports, bound into cmd_sequencer
// checks are off while the stretched reset is high
//////////////////////////////////////////////////////////////////////
module bridge_asserts
  import bridge_pkg::*;
(
  input logic         sys_clk,
  input logic         rst_i,
  input spi_req_t     spi_req_i,
  input logic         spi_busy_i,
  input logic         fifo_rd_i,
  input logic         fifo_empty_i,
  input uart_tx_req_t tx_req_i,
  input logic         tx_active_i
);

  // spi master must be idle when a word is started
  spi_start_idle: assert property (@(posedge sys_clk) disable iff (rst_i)
    !(spi_req_i.start && spi_busy_i))
    else $error("spi start issued while the spi master is busy");

  // no pop from an empty readback fifo
  fifo_rd_not_empty: assert property (@(posedge sys_clk) disable iff (rst_i)
    !(fifo_rd_i && fifo_empty_i))
    else $error("readback fifo read while empty");

  // Reply launch only into an idle transmitter
  tx_start_idle: assert property (@(posedge sys_clk) disable iff (rst_i)
    !(tx_req_i.start && tx_active_i))
    else $error("uart start issued while the transmitter is active");

endmodule

bind cmd_sequencer bridge_asserts u_asserts (
  .sys_clk      (sys_clk),
  .rst_i        (rst_i),
  .spi_req_i    (spi_req_o),
  .spi_busy_i   (spi_busy_i),
  .fifo_rd_i    (fifo_rd_o),
  .fifo_empty_i (fifo_empty_i),
  .tx_req_i     (tx_req_o),
  .tx_active_i  (tx_active_i)
);

/* dv/bridge_tb.sv */
//////////////////////////////////////////////////////////////////////
// testbench for the uart to spi bridge
// the spi slave model loops MOSI back on MISO, so readback = data byte
//////////////////////////////////////////////////////////////////////
module bridge_tb
  import bridge_pkg::*;
();

  localparam int TBL_N          = 8;
  localparam int FRAME_CYCLES   = 10 * CLKS_PER_BIT;
  localparam int TIMEOUT_CYCLES = TBL_N * (3 * FRAME_CYCLES + 200);

  // address column of the stimulus table
  localparam logic [7:0] TBL_ADDR [TBL_N] = '{
    8'h10, 8'h21, 8'h32, 8'h43, 8'h54, 8'h65, 8'h76, 8'h87
  };
  // idle cycles after each pair with zero gaps at the end for back-pressure
  localparam int TBL_GAP [TBL_N] = '{40, 80, 0, 120, 0, 0, 0, 0};

  logic sys_clk    = 1'b0;
  logic spi_sout_i = 1'b0;
  logic reset_all_cmd_w;
  logic uart_rx_i;
  logic uart_tx_o;
  logic spi_sen_o;
  logic spi_sck_o;
  logic spi_sdat_o;
  logic slm_reset_n_o;

  int          seed;
  int          rnd;
  logic [7:0]  tbl_data [TBL_N];
  logic [15:0] spi_q [$];
  logic [7:0]  reply_q [$];
  int          err_cnt       = 0;
  int          check_cnt     = 0;
  int          test_cnt      = 0;
  int          spi_mon_errs  = 0;
  int          uart_mon_errs = 0;
  int          sen_falls     = 0;
  int          cycle_cnt     = 0;
  int          spi_bits;
  logic [15:0] spi_word;
  logic [7:0]  mon_byte;

  always #5 sys_clk = ~sys_clk;

  bridge_top u_dut (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .uart_rx_i       (uart_rx_i),
    .uart_tx_o       (uart_tx_o),
    .spi_sen_o       (spi_sen_o),
    .spi_sck_o       (spi_sck_o),
    .spi_sdat_o      (spi_sdat_o),
    .spi_sout_i      (spi_sout_i),
    .slm_reset_n_o   (slm_reset_n_o)
  );

  //////////////////////////////////////////////////////////////////////
  // serial models

  // slave model presents the current MOSI bit before the next rising SCK
  always @(negedge spi_sck_o or negedge spi_sen_o) begin
    #1;
    spi_sout_i = spi_sdat_o;
  end

  // decode each spi frame from SDAT on rising SCK while SEN stays low
  always @(negedge spi_sen_o) begin
    if (slm_reset_n_o === 1'b1) begin
      sen_falls++;
      spi_word = '0;
      spi_bits = 0;
      while (spi_sen_o === 1'b0) begin
        @(posedge spi_sck_o or posedge spi_sen_o);
        if (spi_sen_o === 1'b0) begin
          spi_word = {spi_word[14:0], spi_sdat_o};
          spi_bits++;
        end
      end
      if (spi_bits != 16) begin
        $display("SPI select rose after %0d clock edges instead of 16", spi_bits);
        spi_mon_errs++;
      end
      spi_q.push_back(spi_word);
    end
  end

  // decode uart replies mid-bit on the falling clock
  always @(negedge uart_tx_o) begin
    if (slm_reset_n_o === 1'b1) begin
      repeat (CLKS_PER_BIT / 2) @(negedge sys_clk);
      if (uart_tx_o !== 1'b0) begin
        $display("uart reply start bit did not last to mid-bit");
        uart_mon_errs++;
      end
      for (int i = 0; i < 8; i++) begin
        repeat (CLKS_PER_BIT) @(negedge sys_clk);
        mon_byte[i] = uart_tx_o;
      end
      repeat (CLKS_PER_BIT) @(negedge sys_clk);
      if (uart_tx_o !== 1'b1) begin
        $display("uart reply has a low stop bit");
        uart_mon_errs++;
      end
      reply_q.push_back(mon_byte);
    end
  end

  // run limit from the table length
  always @(posedge sys_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run still busy after %0d cycles", cycle_cnt);
      $display("*** FAILED ***");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // helpers

  function automatic int total_errors();
    return err_cnt + spi_mon_errs + uart_mon_errs;
  endfunction

  task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
    check_cnt++;
    if (act !== exp) begin
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, act, exp);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    test_cnt++;
    if (total_errors() == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, total_errors() - errs_before);
    end
  endtask

  // send one 8N1 frame LSB first on the host line
  task automatic send_frame(input logic [7:0] b);
    logic [9:0] bits;
    bits = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge sys_clk);
      #1;
      uart_rx_i = bits[i];
      repeat (CLKS_PER_BIT - 1) @(posedge sys_clk);
    end
  endtask

  task automatic take_spi_word(output logic [15:0] w);
    while (spi_q.size() == 0) @(negedge sys_clk);
    w = spi_q.pop_front();
  endtask

  task automatic take_reply(output logic [7:0] r);
    while (reply_q.size() == 0) @(negedge sys_clk);
    r = reply_q.pop_front();
  endtask

  task automatic send_table();
    for (int i = 0; i < TBL_N; i++) begin
      send_frame(TBL_ADDR[i]);
      send_frame(tbl_data[i]);
      repeat (TBL_GAP[i]) @(posedge sys_clk);
    end
  endtask

  // each word is address then data and each reply is the data byte, in table order
  task automatic check_table();
    logic [15:0] word;
    logic [7:0]  reply;
    int          errs;
    for (int i = 0; i < TBL_N; i++) begin
      errs = total_errors();
      take_spi_word(word);
      check_val("spi_word", 32'(word), 32'({TBL_ADDR[i], tbl_data[i]}));
      take_reply(reply);
      check_val("uart_reply", 32'(reply), 32'(tbl_data[i]));
      end_test($sformatf("entry %0d", i), errs);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  initial begin : main_seq
    int          errs;
    int          falls;
    int          hold_cnt;
    logic [15:0] word;
    logic [7:0]  reply;
    reset_all_cmd_w = 1'b1;
    uart_rx_i       = 1'b1;
    seed            = 32'h5313_8765;
    for (int i = 0; i < TBL_N; i++) begin
      rnd         = $random(seed);
      tbl_data[i] = rnd[7:0];
    end

    // count reset low cycles on the falling clock
    errs = total_errors();
    repeat (5) @(posedge sys_clk);
    #1;
    reset_all_cmd_w = 1'b0;
    hold_cnt = 0;
    @(negedge sys_clk);
    while ((slm_reset_n_o !== 1'b1) && (hold_cnt < 4 * RESET_HOLD)) begin
      hold_cnt++;
      @(negedge sys_clk);
    end
    check_val("slm_reset_n_o low cycles", 32'(hold_cnt), 32'(RESET_HOLD));
    check_val("spi_sen_o", 32'(spi_sen_o), 32'd1);
    check_val("spi_sck_o", 32'(spi_sck_o), 32'd0);
    check_val("uart_tx_o", 32'(uart_tx_o), 32'd1);
    end_test("reset", errs);

    // a lone byte must not start a transfer
    errs  = total_errors();
    falls = sen_falls;
    send_frame(8'hA5);
    repeat (100) @(negedge sys_clk);
    check_val("spi frames after lone byte", 32'(sen_falls - falls), 32'd0);
    check_val("spi_sen_o", 32'(spi_sen_o), 32'd1);
    send_frame(8'h3C);
    take_spi_word(word);
    check_val("spi_word", 32'(word), 32'h0000_A53C);
    take_reply(reply);
    check_val("uart_reply", 32'(reply), 32'h0000_003C);
    end_test("pairing", errs);

    fork
      send_table();
      check_table();
    join

    // nothing left over once the line has been quiet a while
    errs = total_errors();
    repeat (2 * FRAME_CYCLES) @(negedge sys_clk);
    check_val("extra spi words", 32'(spi_q.size()), 32'd0);
    check_val("extra uart replies", 32'(reply_q.size()), 32'd0);
    end_test("no extra frames", errs);

    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, total_errors());
    if (total_errors() == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* all.f */
common/bridge_pkg.sv
design/reset_stretch.sv
uart/uart_rx.sv
uart/uart_tx.sv
spi/spi_master.sv
design/readback_fifo.sv
design/cmd_sequencer.sv
design/bridge_top.sv
dv/bridge_asserts.sv
dv/bridge_tb.sv

/* Makefile */
# Verilator build and run of the uart to spi bridge testbench
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run bridge_tb, fail on a failing log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f all.f --top-module bridge_tb -Mdir obj_dir
	./obj_dir/Vbridge_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG) || ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then \
	  echo "simulation failed"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)
